// ==== verilog/mipsPkg.sv ====
package mipsPkg;

	localparam int dataWidth = 32; // One machine word
	localparam int regAddrWidth = 5; // 32 registers

	// One instruction word seen as R-type or I-type fields
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} iType;
	} instrWord;

	// Opcodes
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti = 6'h0a;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opXori = 6'h0e;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	// R-type function field
	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnSrl = 6'h02;
	localparam logic [5:0] fnSra = 6'h03;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

	// ALU operations, mostly the funct encoding
	localparam logic [5:0] aluOpSll = 6'b000000;
	localparam logic [5:0] aluOpSrl = 6'b000010;
	localparam logic [5:0] aluOpSra = 6'b000011;
	localparam logic [5:0] aluOpAdd = 6'b100000;
	localparam logic [5:0] aluOpSub = 6'b100010;
	localparam logic [5:0] aluOpAnd = 6'b100100;
	localparam logic [5:0] aluOpOr = 6'b100101;
	localparam logic [5:0] aluOpXor = 6'b100110;
	localparam logic [5:0] aluOpNor = 6'b100111;
	localparam logic [5:0] aluOpSlt = 6'b101010;
	localparam logic [5:0] aluOpSltu = 6'b101011;
	localparam logic [5:0] aluOpLui = 6'b111111;

	// ALU mode from the control unit
	localparam logic [2:0] modeFunct = 3'd0; // Decode funct field
	localparam logic [2:0] modeAdd = 3'd1;
	localparam logic [2:0] modeSub = 3'd2;
	localparam logic [2:0] modeSlt = 3'd3;
	localparam logic [2:0] modeAnd = 3'd4;
	localparam logic [2:0] modeOr = 3'd5;
	localparam logic [2:0] modeXor = 3'd6;
	localparam logic [2:0] modeLui = 3'd7;

	// ALU second operand select
	localparam logic [1:0] srcReg = 2'd0;
	localparam logic [1:0] srcImm = 2'd1;
	localparam logic [1:0] srcShamt = 2'd2;

	// Control FSM states
	localparam logic [3:0] stFetch = 4'd0;
	localparam logic [3:0] stDecode = 4'd1;
	localparam logic [3:0] stExecR = 4'd2;
	localparam logic [3:0] stExecI = 4'd3;
	localparam logic [3:0] stAddrCalc = 4'd4;
	localparam logic [3:0] stMemRead = 4'd5;
	localparam logic [3:0] stMemWrite = 4'd6;
	localparam logic [3:0] stWriteReg = 4'd7;
	localparam logic [3:0] stWriteMem = 4'd8;
	localparam logic [3:0] stBranch = 4'd9;

endpackage

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ns

module registerFile import mipsPkg::*; (
	input logic CLK,
	input logic regWrite,
	input logic [regAddrWidth-1:0] writeAddr,
	input logic [dataWidth-1:0] writeData,
	input logic [regAddrWidth-1:0] readAddrA,
	input logic [regAddrWidth-1:0] readAddrB,
	output logic [dataWidth-1:0] readDataA,
	output logic [dataWidth-1:0] readDataB
);

	logic [dataWidth-1:0] regs [0:(1 << regAddrWidth)-1];

	// R0 never written
	always_ff @(posedge CLK) begin
		if (regWrite && writeAddr != '0)
			regs[writeAddr] <= writeData;
	end

	// Combinational reads, R0 forced to zero
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ns

module alu import mipsPkg::*; (
	input logic [5:0] operation,
	input logic [dataWidth-1:0] operandA,
	input logic [dataWidth-1:0] operandB,
	output logic [dataWidth-1:0] result,
	output logic zero
);

	logic [4:0] shiftAmount;
	logic lessSigned;
	logic lessUnsigned;

	assign shiftAmount = operandB[4:0]; // Low five bits only
	assign lessSigned = $signed(operandA) < $signed(operandB);
	assign lessUnsigned = operandA < operandB;

	always_comb begin
		case (operation)
			aluOpAdd: result = operandA + operandB; // Wraps
			aluOpSub: result = operandA - operandB;
			aluOpAnd: result = operandA & operandB;
			aluOpOr: result = operandA | operandB;
			aluOpXor: result = operandA ^ operandB;
			aluOpNor: result = ~(operandA | operandB);
			aluOpSlt: begin
				result = '0;
				result[0] = lessSigned;
			end
			aluOpSltu: begin
				result = '0;
				result[0] = lessUnsigned;
			end
			aluOpSll: result = operandA << shiftAmount;
			aluOpSrl: result = operandA >> shiftAmount;
			aluOpSra: result = $signed(operandA) >>> shiftAmount; // Sign fill
			aluOpLui: result = operandB << 16; // Immediate to upper half
			default: result = operandA + operandB;
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== verilog/aluDecoder.sv ====
`timescale 1ns/1ns

module aluDecoder import mipsPkg::*; (
	input logic [2:0] aluMode,
	input logic [5:0] funct,
	output logic [5:0] operation
);

	always_comb begin
		case (aluMode)
			modeFunct: begin
				case (funct)
					fnAdd, fnAddu: operation = aluOpAdd; // No overflow trap
					fnSub, fnSubu: operation = aluOpSub;
					fnAnd: operation = aluOpAnd;
					fnOr: operation = aluOpOr;
					fnXor: operation = aluOpXor;
					fnNor: operation = aluOpNor;
					fnSlt: operation = aluOpSlt;
					fnSltu: operation = aluOpSltu;
					fnSll: operation = aluOpSll;
					fnSrl: operation = aluOpSrl;
					fnSra: operation = aluOpSra;
					default: operation = aluOpAdd;
				endcase
			end
			modeSub: operation = aluOpSub; // Branch compare
			modeSlt: operation = aluOpSlt;
			modeAnd: operation = aluOpAnd;
			modeOr: operation = aluOpOr;
			modeXor: operation = aluOpXor;
			modeLui: operation = aluOpLui;
			default: operation = aluOpAdd; // Address calc and ADDI
		endcase
	end

endmodule

// ==== verilog/datapath.sv ====
`timescale 1ns/1ns

module datapath import mipsPkg::*; #(
	parameter int addrWidth = 9
) (
	input logic CLK,
	input logic reset,
	input logic [dataWidth-1:0] memReadData,
	input logic memDone,
	input logic pcWrite,
	input logic irWrite,
	input logic branchEq,
	input logic branchNe,
	input logic regWrite,
	input logic regDstRd,
	input logic regFromMem,
	input logic zeroExtend,
	input logic addrFromAlu,
	input logic [1:0] aluSrc,
	input logic [2:0] aluMode,
	output logic [5:0] opcode,
	output logic [addrWidth-1:0] memAddress,
	output logic [dataWidth-1:0] memWriteData
);

	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] branchTarget;
	instrWord ir;
	logic [dataWidth-1:0] regA, regB; // Operand registers
	logic [dataWidth-1:0] aluOut; // ALU result register
	logic [dataWidth-1:0] loadData; // Word from LW
	logic [dataWidth-1:0] readDataA, readDataB;
	logic [dataWidth-1:0] signImm, extImm, branchOffset;
	logic [dataWidth-1:0] operandA, operandB, aluResult, writeData;
	logic [regAddrWidth-1:0] writeAddr;
	logic [5:0] operation;
	logic [1:0] srcSel;
	logic shiftOp;
	logic zero;
	logic takeBranch;

	assign opcode = ir.rType.opcode;

	// Immediate forms
	assign signImm = {{(dataWidth-16){ir.iType.imm[15]}}, ir.iType.imm};
	assign extImm = zeroExtend ? {{(dataWidth-16){1'b0}}, ir.iType.imm} : signImm;
	assign branchOffset = {signImm[dataWidth-3:0], 2'b00}; // Word offset to bytes
	assign branchTarget = pc + branchOffset[addrWidth-1:0]; // PC already at branch + 4

	assign takeBranch = (branchEq && zero) || (branchNe && !zero);

	always_ff @(posedge CLK) begin
		if (reset)
			pc <= '0;
		else if (pcWrite)
			pc <= pc + addrWidth'(4);
		else if (takeBranch)
			pc <= branchTarget;
	end

	// Payload registers
	always_ff @(posedge CLK) begin
		if (irWrite && memDone)
			ir <= memReadData;
		if (regFromMem && memDone)
			loadData <= memReadData;
		regA <= readDataA; // IR is stable so reloading is harmless
		regB <= readDataB;
		aluOut <= aluResult;
	end

	// Shifts take rt as the value and shamt as the distance
	assign shiftOp = (operation == aluOpSll) || (operation == aluOpSrl) ||
		(operation == aluOpSra);
	assign srcSel = (aluSrc == srcReg && shiftOp) ? srcShamt : aluSrc;

	always_comb begin
		operandA = regA;
		case (srcSel)
			srcImm: operandB = extImm;
			srcShamt: begin
				operandA = regB;
				operandB = {{(dataWidth-5){1'b0}}, ir.rType.shamt};
			end
			default: operandB = regB;
		endcase
	end

	assign writeAddr = regDstRd ? ir.rType.rd : ir.rType.rt;
	assign writeData = regFromMem ? loadData : aluOut;

	// Word aligned bus address
	assign memAddress = addrFromAlu ? {aluOut[addrWidth-1:2], 2'b00} : pc;
	assign memWriteData = regB; // SW data is rt

	registerFile regFile0 (
		.CLK(CLK),
		.regWrite(regWrite),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.readAddrA(ir.iType.rs),
		.readAddrB(ir.iType.rt),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	aluDecoder aluDecoder0 (
		.aluMode(aluMode),
		.funct(ir.rType.funct),
		.operation(operation)
	);

	alu alu0 (
		.operation(operation),
		.operandA(operandA),
		.operandB(operandB),
		.result(aluResult),
		.zero(zero)
	);

endmodule

// ==== verilog/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit import mipsPkg::*; (
	input logic CLK,
	input logic reset,
	input logic [5:0] opcode,
	input logic memDone,
	output logic pcWrite, // PC <= PC + 4
	output logic irWrite,
	output logic branchEq,
	output logic branchNe,
	output logic regWrite,
	output logic regDstRd, // rd instead of rt
	output logic regFromMem, // Loaded word instead of ALU result
	output logic zeroExtend,
	output logic addrFromAlu, // Memory address from ALU result
	output logic [1:0] aluSrc,
	output logic [2:0] aluMode,
	output logic memRead,
	output logic memWrite
);

	logic [3:0] state;
	logic [3:0] nextState;
	logic memAck; // Outstanding request completes this edge
	logic isLoad;

	assign memAck = memDone && (memRead || memWrite);
	assign isLoad = (opcode == opLw);

	// Strobes are registered so they stay low for a cycle after reset
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= stFetch;
			memRead <= 1'b0;
			memWrite <= 1'b0;
		end else begin
			state <= nextState;
			memRead <= (nextState == stFetch) || (nextState == stMemRead);
			memWrite <= (nextState == stMemWrite);
		end
	end

	always_comb begin
		nextState = stFetch;
		case (state)
			stFetch: nextState = memAck ? stDecode : stFetch; // Wait for the word
			stDecode: begin
				case (opcode)
					opRType: nextState = stExecR;
					opAddi, opAddiu, opSlti,
					opAndi, opOri, opXori, opLui: nextState = stExecI;
					opLw, opSw: nextState = stAddrCalc;
					opBeq, opBne: nextState = stBranch;
					default: nextState = stFetch; // Unknown opcode is a no-op
				endcase
			end
			stExecR, stExecI: nextState = stWriteReg;
			stAddrCalc: nextState = isLoad ? stMemRead : stMemWrite;
			stMemRead: nextState = memAck ? stWriteReg : stMemRead;
			stMemWrite: nextState = memAck ? stFetch : stMemWrite; // Store ends here
			stWriteReg: nextState = stFetch;
			stBranch: nextState = stFetch;
			default: nextState = stFetch;
		endcase
	end

	always_comb begin
		// Address add on the immediate unless a state says otherwise
		pcWrite = 1'b0;
		irWrite = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		regWrite = 1'b0;
		regDstRd = 1'b0;
		regFromMem = 1'b0;
		zeroExtend = 1'b0;
		addrFromAlu = 1'b0;
		aluSrc = srcImm;
		aluMode = modeAdd;
		case (state)
			stFetch: begin
				irWrite = memRead; // Datapath loads on memDone
				pcWrite = memAck;
			end
			stExecR: begin
				aluSrc = srcReg; // Datapath swaps in shamt for shifts
				aluMode = modeFunct;
			end
			stExecI: begin
				case (opcode)
					opSlti: aluMode = modeSlt;
					opAndi: aluMode = modeAnd;
					opOri: aluMode = modeOr;
					opXori: aluMode = modeXor;
					opLui: aluMode = modeLui;
					default: aluMode = modeAdd; // ADDI, ADDIU
				endcase
				zeroExtend = (opcode == opAndi) || (opcode == opOri) || (opcode == opXori);
			end
			stMemRead: begin
				addrFromAlu = 1'b1; // Keeps adding base + offset meanwhile
				regFromMem = 1'b1;
			end
			stMemWrite: addrFromAlu = 1'b1;
			stWriteReg: begin
				regWrite = 1'b1;
				regDstRd = (opcode == opRType);
				regFromMem = isLoad;
			end
			stBranch: begin
				aluSrc = srcReg;
				aluMode = modeSub; // Zero flag gives A == B
				branchEq = (opcode == opBeq);
				branchNe = (opcode == opBne);
			end
			default: ;
		endcase
	end

endmodule

// ==== verilog/mipsCpu.sv ====
`timescale 1ns/1ns

module mipsCpu import mipsPkg::*; #(
	parameter int addrWidth = 9 // Byte address bits
) (
	input logic CLK,
	input logic reset,
	input logic [dataWidth-1:0] memReadData,
	input logic memDone, // One-cycle completion pulse
	output logic [addrWidth-1:0] memAddress,
	output logic [dataWidth-1:0] memWriteData,
	output logic memRead,
	output logic memWrite
);

	// Control lines into the datapath
	logic pcWrite, irWrite;
	logic branchEq, branchNe;
	logic regWrite, regDstRd, regFromMem;
	logic zeroExtend, addrFromAlu;
	logic [1:0] aluSrc;
	logic [2:0] aluMode;
	logic [5:0] opcode; // Back from the IR

	controlUnit control0 (
		.CLK(CLK), .reset(reset), .opcode(opcode), .memDone(memDone),
		.pcWrite(pcWrite), .irWrite(irWrite),
		.branchEq(branchEq), .branchNe(branchNe),
		.regWrite(regWrite), .regDstRd(regDstRd), .regFromMem(regFromMem),
		.zeroExtend(zeroExtend), .addrFromAlu(addrFromAlu),
		.aluSrc(aluSrc), .aluMode(aluMode),
		.memRead(memRead), .memWrite(memWrite)
	);

	datapath #(.addrWidth(addrWidth)) datapath0 (
		.CLK(CLK), .reset(reset),
		.memReadData(memReadData), .memDone(memDone),
		.pcWrite(pcWrite), .irWrite(irWrite),
		.branchEq(branchEq), .branchNe(branchNe),
		.regWrite(regWrite), .regDstRd(regDstRd), .regFromMem(regFromMem),
		.zeroExtend(zeroExtend), .addrFromAlu(addrFromAlu),
		.aluSrc(aluSrc), .aluMode(aluMode),
		.opcode(opcode), .memAddress(memAddress), .memWriteData(memWriteData)
	);

endmodule

// ==== include/mipsEncode.svh ====
`ifndef MIPS_ENCODE_SVH
`define MIPS_ENCODE_SVH

// R-type word from its fields
function automatic logic [dataWidth-1:0] encodeR(input logic [5:0] funct,
		input logic [regAddrWidth-1:0] rd, input logic [regAddrWidth-1:0] rs,
		input logic [regAddrWidth-1:0] rt, input logic [4:0] shamt);
	instrWord word;
	word.rType.opcode = opRType;
	word.rType.rs = rs;
	word.rType.rt = rt;
	word.rType.rd = rd;
	word.rType.shamt = shamt;
	word.rType.funct = funct;
	return word;
endfunction

// I-type word, also loads, stores and branches
function automatic logic [dataWidth-1:0] encodeI(input logic [5:0] opcode,
		input logic [regAddrWidth-1:0] rt, input logic [regAddrWidth-1:0] rs,
		input logic [15:0] imm);
	instrWord word;
	word.iType.opcode = opcode;
	word.iType.rs = rs;
	word.iType.rt = rt;
	word.iType.imm = imm;
	return word;
endfunction

`endif

// ==== test/mipsCpuTb.sv ====
`timescale 1ns/1ns

module mipsCpuTb import mipsPkg::*; ();

	`include "mipsEncode.svh"

	localparam int worstCycles = 11; // Fetch 4, decode 1, address 1, memory 4, write-back 1
	localparam int resetCycles = 10;

	logic CLK;
	logic reset;
	logic [dataWidth-1:0] memReadData, memWriteData;
	logic memDone, memRead, memWrite;
	logic [8:0] memAddress;

	logic [31:0] memArray [0:127]; // Word memory behind the DUT
	logic [31:0] refMem [0:127]; // Reference model memory
	logic [31:0] refRegs [0:31];
	bit logKind[$]; // 1 marks a write
	logic [8:0] logAddr[$];
	logic [31:0] logData[$]; // Store data, zero for reads
	bit expKind[$];
	logic [8:0] expAddr[$];
	logic [31:0] expData[$];

	integer seed = 14793;
	int cycleCount = 0;
	int cycleLimit = 2 * resetCycles; // Grows by each test's budget
	int progWords, waitLeft, instrCount;
	logic [15:0] storeAddr; // Next result slot
	logic resetSampled = 1'b1;
	logic busy, reqWrite;
	logic [8:0] reqAddr;
	logic [31:0] reqData;
	string testName;

	mipsCpu #(.addrWidth(9)) dut0 (
		.CLK(CLK), .reset(reset),
		.memReadData(memReadData), .memDone(memDone),
		.memAddress(memAddress), .memWriteData(memWriteData),
		.memRead(memRead), .memWrite(memWrite)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		resetSampled <= reset; // Reset as the DUT saw it
		cycleCount <= cycleCount + 1;
		assert (cycleCount <= cycleLimit)
		else begin
			$display("Timeout after %0d cycles, the program never reached its end", cycleCount);
			stopRun();
		end
	end

	task automatic stopRun();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("ERROR %s %s: expected %h, actual %h", testName, what, expected, actual);
			stopRun();
		end
	endtask

	task automatic completeRequest();
		if (reqWrite)
			memArray[reqAddr[8:2]] = reqData;
		else
			memReadData = memArray[reqAddr[8:2]];
		memDone = 1'b1; // One-cycle pulse
		logKind.push_back(reqWrite);
		logAddr.push_back(reqAddr);
		logData.push_back(reqWrite ? reqData : 32'h0);
	endtask

	// Memory model, 1 to 4 cycles per request
	initial begin
		memDone = 1'b0;
		memReadData = '0;
		busy = 1'b0;
		forever begin
			@(negedge CLK);
			if (memDone) begin
				memDone = 1'b0; // DUT dropped the request at the last edge
				busy = 1'b0;
			end
			if (resetSampled) begin
				assert (memRead !== 1'b1 && memWrite !== 1'b1)
				else begin
					$display("Memory strobe high while reset was asserted");
					stopRun();
				end
				busy = 1'b0;
			end else if (busy) begin
				assert (memWrite === reqWrite && memRead === !reqWrite &&
						memAddress === reqAddr && (!reqWrite || memWriteData === reqData))
				else begin
					$display("Memory request dropped or changed before memDone at %0t", $time);
					stopRun();
				end
				waitLeft--;
				if (waitLeft == 0)
					completeRequest();
			end else if (memRead || memWrite) begin
				assert (!(memRead && memWrite) && memAddress[1:0] == 2'b00)
				else begin
					$display("Read and write together or unaligned address %h", memAddress);
					stopRun();
				end
				busy = 1'b1;
				reqWrite = memWrite;
				reqAddr = memAddress;
				reqData = memWriteData;
				waitLeft = $random(seed) & 3; // Extra wait cycles
				if (waitLeft == 0)
					completeRequest();
			end
		end
	end

	task automatic expectRequest(input bit isWrite, input logic [8:0] addr,
			input logic [31:0] data);
		expKind.push_back(isWrite);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// Reference model of the instruction subset, run up to the halt fetch
	task automatic runModel();
		logic [31:0] word, a, b, simm, zimm, result;
		logic [8:0] pc, addr;
		logic [4:0] dest;
		bit writes;
		for (int i = 0; i < 32; i++)
			refRegs[i] = '0;
		for (int i = 0; i < 128; i++)
			refMem[i] = memArray[i];
		expKind.delete();
		expAddr.delete();
		expData.delete();
		pc = '0;
		instrCount = 0;
		while (instrCount < 1000) begin
			word = refMem[pc[8:2]];
			expectRequest(1'b0, pc, 32'h0); // Fetch
			instrCount++;
			if (word == encodeI(opBeq, 5'd0, 5'd0, 16'hffff))
				break;
			a = refRegs[word[25:21]];
			b = refRegs[word[20:16]];
			simm = {{16{word[15]}}, word[15:0]};
			zimm = {16'h0, word[15:0]};
			addr = {a[8:0] + simm[8:0]} & 9'h1fc;
			dest = word[20:16];
			writes = 1'b1;
			result = '0;
			pc = pc + 9'd4;
			case (word[31:26])
				opRType: begin
					dest = word[15:11];
					case (word[5:0])
						fnAdd, fnAddu: result = a + b;
						fnSub, fnSubu: result = a - b;
						fnAnd: result = a & b;
						fnOr: result = a | b;
						fnXor: result = a ^ b;
						fnNor: result = ~(a | b);
						fnSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						fnSltu: result = (a < b) ? 32'd1 : 32'd0;
						fnSll: result = b << word[10:6];
						fnSrl: result = b >> word[10:6];
						fnSra: result = $signed(b) >>> word[10:6];
						default: writes = 1'b0;
					endcase
				end
				opAddi, opAddiu: result = a + simm;
				opSlti: result = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
				opAndi: result = a & zimm;
				opOri: result = a | zimm;
				opXori: result = a ^ zimm;
				opLui: result = {word[15:0], 16'h0};
				opLw: begin
					expectRequest(1'b0, addr, 32'h0);
					result = refMem[addr[8:2]];
				end
				opSw: begin
					writes = 1'b0;
					expectRequest(1'b1, addr, b);
					refMem[addr[8:2]] = b;
				end
				opBeq, opBne: begin
					writes = 1'b0;
					if ((a == b) == (word[31:26] == opBeq))
						pc = pc + {simm[6:0], 2'b00}; // From the branch plus 4
				end
				default: writes = 1'b0;
			endcase
			if (writes && dest != 5'd0)
				refRegs[dest] = result;
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		@(negedge CLK);
		reset = 1'b1;
		repeat (2) @(negedge CLK);
		for (int i = 0; i < 128; i++)
			memArray[i] = 32'hc0de0000 | (i << 2); // Fill tied to the byte address
		progWords = 0;
		storeAddr = 16'h100;
	endtask

	task automatic runTest();
		runModel();
		cycleLimit = cycleLimit + resetCycles + instrCount * worstCycles * 2;
		repeat (resetCycles - 2) @(negedge CLK);
		logKind.delete();
		logAddr.delete();
		logData.delete();
		reset = 1'b0;
		while (logKind.size() < expKind.size())
			@(negedge CLK);
		for (int i = 0; i < expKind.size(); i++) begin
			checkValue($sformatf("request %0d kind", i), expKind[i], logKind[i]);
			checkValue($sformatf("request %0d address", i), expAddr[i], logAddr[i]);
			checkValue($sformatf("request %0d store data", i), expData[i], logData[i]);
		end
		for (int i = 0; i < 128; i++)
			checkValue($sformatf("memory word %0d", i), refMem[i], memArray[i]);
	endtask

	task automatic appendWord(input logic [31:0] word);
		memArray[progWords] = word;
		progWords++;
	endtask

	task automatic appendRAndStore(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] shamt);
		appendWord(encodeR(funct, 5'd4, rs, rt, shamt)); // Result in r4
		appendWord(encodeI(opSw, 5'd4, 5'd0, storeAddr));
		storeAddr = storeAddr + 16'd4;
	endtask

	task automatic appendIAndStore(input logic [5:0] opcode, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		appendWord(encodeI(opcode, rt, rs, imm));
		appendWord(encodeI(opSw, rt, 5'd0, storeAddr));
		storeAddr = storeAddr + 16'd4;
	endtask

	task automatic appendHalt();
		appendWord(encodeI(opBeq, 5'd0, 5'd0, 16'hffff)); // Branch to itself
	endtask

	task automatic resetFetchTest();
		startTest("resetFetch");
		appendWord(encodeI(opAddi, 5'd1, 5'd0, 16'd5));
		appendWord(encodeI(opAddi, 5'd2, 5'd1, 16'd7));
		appendWord(encodeI(opSw, 5'd2, 5'd0, 16'h100));
		appendHalt();
		runTest();
	endtask

	task automatic rTypeTest();
		startTest("rType");
		appendWord(encodeI(opAddi, 5'd1, 5'd0, 16'hfffd)); // r1 = -3
		appendWord(encodeI(opLui, 5'd2, 5'd0, 16'h7fff));
		appendWord(encodeI(opOri, 5'd2, 5'd2, 16'hffff)); // Largest positive
		appendWord(encodeI(opAddi, 5'd3, 5'd0, 16'd9));
		appendRAndStore(fnAdd, 5'd2, 5'd3, 5'd0); // Wraps
		appendRAndStore(fnAddu, 5'd1, 5'd3, 5'd0);
		appendRAndStore(fnSub, 5'd3, 5'd1, 5'd0);
		appendRAndStore(fnSubu, 5'd1, 5'd2, 5'd0);
		appendRAndStore(fnAnd, 5'd1, 5'd2, 5'd0);
		appendRAndStore(fnOr, 5'd1, 5'd3, 5'd0);
		appendRAndStore(fnXor, 5'd1, 5'd2, 5'd0);
		appendRAndStore(fnNor, 5'd1, 5'd3, 5'd0);
		appendRAndStore(fnSlt, 5'd1, 5'd3, 5'd0); // Negative below 9
		appendRAndStore(fnSltu, 5'd1, 5'd3, 5'd0); // But not unsigned
		appendRAndStore(fnSll, 5'd0, 5'd1, 5'd4);
		appendRAndStore(fnSrl, 5'd0, 5'd1, 5'd4);
		appendRAndStore(fnSra, 5'd0, 5'd1, 5'd4); // Sign fill
		appendHalt();
		runTest();
	endtask

	task automatic immediateTest();
		startTest("immediate");
		appendIAndStore(opAddi, 5'd1, 5'd0, 16'hff9c);
		appendIAndStore(opAddiu, 5'd2, 5'd1, 16'h8000);
		appendIAndStore(opLui, 5'd3, 5'd0, 16'hf0f0);
		appendIAndStore(opOri, 5'd3, 5'd3, 16'h8421); // Zero extended
		appendIAndStore(opAndi, 5'd4, 5'd1, 16'hff00);
		appendIAndStore(opXori, 5'd5, 5'd1, 16'h8001);
		appendIAndStore(opSlti, 5'd6, 5'd1, 16'hffff);
		appendIAndStore(opSlti, 5'd7, 5'd1, 16'h8000);
		appendIAndStore(opSlti, 5'd8, 5'd1, 16'd5); // Set only when signed
		appendHalt();
		runTest();
	endtask

	task automatic loadStoreTest();
		startTest("loadStore");
		memArray[80] = 32'h12345678; // Byte 0x140
		memArray[81] = 32'h89abcdef;
		memArray[82] = 32'h0f0f00f0;
		memArray[83] = 32'h80000001;
		appendWord(encodeI(opLw, 5'd1, 5'd0, 16'h140));
		appendWord(encodeI(opLw, 5'd2, 5'd0, 16'h144));
		appendWord(encodeI(opAddi, 5'd5, 5'd0, 16'h140)); // Source base
		appendWord(encodeI(opLw, 5'd3, 5'd5, 16'd8));
		appendWord(encodeI(opAddi, 5'd6, 5'd0, 16'h180)); // Destination base
		appendWord(encodeR(fnAdd, 5'd4, 5'd1, 5'd2, 5'd0));
		appendWord(encodeI(opSw, 5'd4, 5'd6, 16'd0));
		appendWord(encodeR(fnXor, 5'd4, 5'd3, 5'd1, 5'd0));
		appendWord(encodeI(opSw, 5'd4, 5'd6, 16'd4));
		appendWord(encodeI(opSw, 5'd3, 5'd6, 16'd8));
		appendWord(encodeI(opSw, 5'd2, 5'd6, 16'hfffc)); // Negative offset
		appendWord(encodeI(opLw, 5'd7, 5'd5, 16'd12));
		appendWord(encodeI(opSw, 5'd7, 5'd6, 16'd12));
		appendHalt();
		runTest();
	endtask

	task automatic branchTest();
		startTest("branch");
		appendWord(encodeI(opAddi, 5'd1, 5'd0, 16'd7));
		appendWord(encodeI(opAddi, 5'd2, 5'd0, 16'd7));
		appendWord(encodeI(opAddi, 5'd3, 5'd0, 16'd1));
		appendWord(encodeI(opBeq, 5'd2, 5'd1, 16'd2)); // Taken forward
		appendWord(encodeI(opSw, 5'd3, 5'd0, 16'h100)); // Skipped
		appendWord(encodeI(opSw, 5'd3, 5'd0, 16'h104));
		appendWord(encodeI(opBne, 5'd2, 5'd1, 16'd1)); // Not taken
		appendWord(encodeI(opSw, 5'd3, 5'd0, 16'h108));
		appendWord(encodeI(opBeq, 5'd3, 5'd1, 16'd1)); // Not taken
		appendWord(encodeI(opSw, 5'd3, 5'd0, 16'h10c));
		appendWord(encodeI(opAddi, 5'd4, 5'd0, 16'd3)); // Loop count
		appendWord(encodeI(opAddi, 5'd4, 5'd4, 16'hffff));
		appendWord(encodeI(opSw, 5'd4, 5'd0, 16'h110));
		appendWord(encodeI(opBne, 5'd0, 5'd4, 16'hfffd)); // Backward while r4 != 0
		appendWord(encodeI(opBeq, 5'd0, 5'd0, 16'd2));
		appendWord(encodeI(opSw, 5'd3, 5'd0, 16'h114)); // Reached from below only
		appendWord(encodeI(opBeq, 5'd0, 5'd0, 16'd2));
		appendWord(encodeI(opSw, 5'd3, 5'd0, 16'h118));
		appendWord(encodeI(opBeq, 5'd3, 5'd3, 16'hfffc)); // Taken backward
		appendHalt();
		runTest();
	endtask

	initial begin
		reset = 1'b1;
		resetFetchTest();
		rTypeTest();
		immediateTest();
		loadStoreTest();
		branchTest();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== mipsCpu.f ====
+incdir+include
verilog/mipsPkg.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/aluDecoder.sv
verilog/datapath.sv
verilog/controlUnit.sv
verilog/mipsCpu.sv
test/mipsCpuTb.sv
